//--- hdl/rv_pkg.sv
// rv32i core shared definitions
package rv_pkg;

  localparam int xlen       = 32;  // register and address width
  localparam int reg_addr_w = 5;
  localparam int rom_words  = 256;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;
  typedef logic [3:0]            strb_t;   // one bit per byte lane
  typedef logic [6:0]            opcode_t;
  typedef logic [2:0]            funct3_t;

  // major opcodes
  localparam opcode_t op_lui     = 7'b0110111;
  localparam opcode_t op_auipc   = 7'b0010111;
  localparam opcode_t op_jal     = 7'b1101111;
  localparam opcode_t op_jalr    = 7'b1100111;
  localparam opcode_t op_branch  = 7'b1100011;
  localparam opcode_t op_load    = 7'b0000011;
  localparam opcode_t op_store   = 7'b0100011;
  localparam opcode_t op_reg_imm = 7'b0010011;
  localparam opcode_t op_reg_reg = 7'b0110011;
  localparam opcode_t op_system  = 7'b1110011;

  // memory access width in funct3
  localparam funct3_t f3_byte   = 3'b000;
  localparam funct3_t f3_half   = 3'b001;
  localparam funct3_t f3_word   = 3'b010;
  localparam funct3_t f3_byte_u = 3'b100;
  localparam funct3_t f3_half_u = 3'b101;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b  // lui
  } alu_op_t;

  typedef enum logic [1:0] {
    st_fetch,
    st_exec,
    st_mem,
    st_halted
  } cpu_state_t;

endpackage

//--- hdl/inst_rom.sv
// instruction rom
`timescale 1ns/1ps

module inst_rom #(
  parameter int depth = rv_pkg::rom_words
) (
  input  logic         clk,
  input  rv_pkg::word_t pc,
  output rv_pkg::word_t inst
);
  import rv_pkg::*;

  localparam int aw = $clog2(depth);

  word_t rom [depth];

  initial $readmemh("sim/prog.hex", rom);

  always_ff @(posedge clk) begin
    inst <= rom[pc[aw+1:2]];  // word index, byte offset dropped
  end

endmodule

//--- hdl/decoder.sv
// instruction decoder
`timescale 1ns/1ps

module decoder (
  input  rv_pkg::word_t     inst,
  input  rv_pkg::word_t     pc,
  input  rv_pkg::word_t     rs1_data,
  input  rv_pkg::word_t     rs2_data,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::alu_op_t   alu_op,
  output rv_pkg::word_t     alu_a,
  output rv_pkg::word_t     alu_b,
  output rv_pkg::word_t     imm,
  output logic              wb_link,
  output logic              wb_en,
  output logic              is_load,
  output logic              is_store,
  output logic              is_branch,
  output logic              is_jump,
  output logic              is_jalr,
  output logic              is_ecall,
  output rv_pkg::funct3_t   mem_size
);
  import rv_pkg::*;

  opcode_t    opcode;
  logic [6:0] funct7;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode   = inst[6:0];
  assign funct7   = inst[31:25];
  assign rd       = inst[11:7];
  assign rs1      = inst[19:15];
  assign rs2      = inst[24:20];
  assign mem_size = inst[14:12];  // also picks the branch condition

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign is_load   = (opcode == op_load);
  assign is_store  = (opcode == op_store);
  assign is_branch = (opcode == op_branch);
  assign is_jump   = (opcode == op_jal);
  assign is_jalr   = (opcode == op_jalr);
  assign is_ecall  = (opcode == op_system) && (inst[31:7] == 25'd0);
  assign wb_link   = is_jump || is_jalr;
  assign wb_en     = (opcode == op_lui) || (opcode == op_auipc) || wb_link || is_load ||
                     (opcode == op_reg_imm) || (opcode == op_reg_reg);

  always_comb begin
    case (opcode)
      op_lui, op_auipc: imm = imm_u;
      op_jal:           imm = imm_j;
      op_branch:        imm = imm_b;
      op_store:         imm = imm_s;
      default:          imm = imm_i;
    endcase
  end

  assign alu_a = (opcode == op_auipc) ? pc : rs1_data;
  assign alu_b = (opcode == op_reg_reg) ? rs2_data : imm;

  always_comb begin
    alu_op = alu_add;  // address and jalr target
    if (opcode == op_lui) begin
      alu_op = alu_pass_b;
    end else if (opcode == op_reg_imm || opcode == op_reg_reg) begin
      case (mem_size)
        3'b000:  alu_op = (opcode == op_reg_reg && funct7[5]) ? alu_sub : alu_add;
        3'b001:  alu_op = alu_sll;
        3'b010:  alu_op = alu_slt;
        3'b011:  alu_op = alu_sltu;
        3'b100:  alu_op = alu_xor;
        3'b101:  alu_op = funct7[5] ? alu_sra : alu_srl;  // srai has imm bit 10 set
        3'b110:  alu_op = alu_or;
        default: alu_op = alu_and;
      endcase
    end
  end

endmodule

//--- hdl/reg_file.sv
// integer register file
`timescale 1ns/1ps

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  logic              we,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     rd_data,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);
  import rv_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];  // x0 hardwired
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hdl/alu.sv
// alu and branch compare
`timescale 1ns/1ps

module alu (
  input  rv_pkg::alu_op_t op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::funct3_t funct3,
  output rv_pkg::word_t   y,
  input  rv_pkg::word_t   cmp_a,
  input  rv_pkg::word_t   cmp_b,
  output logic            take
);
  import rv_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add:    y = a + b;
      alu_sub:    y = a - b;
      alu_sll:    y = a << shamt;
      alu_slt:    y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      alu_sltu:   y = (a < b) ? 32'd1 : 32'd0;
      alu_xor:    y = a ^ b;
      alu_srl:    y = a >> shamt;
      alu_sra:    y = $signed(a) >>> shamt;  // sign fill
      alu_or:     y = a | b;
      alu_and:    y = a & b;
      alu_pass_b: y = b;
      default:    y = '0;
    endcase
  end

  // branch condition on the raw register values
  always_comb begin
    case (funct3)
      3'b000:  take = (cmp_a == cmp_b);                    // beq
      3'b001:  take = (cmp_a != cmp_b);                    // bne
      3'b100:  take = ($signed(cmp_a) < $signed(cmp_b));   // blt
      3'b101:  take = ($signed(cmp_a) >= $signed(cmp_b));  // bge
      3'b110:  take = (cmp_a < cmp_b);                     // bltu
      3'b111:  take = (cmp_a >= cmp_b);                    // bgeu
      default: take = 1'b0;
    endcase
  end

endmodule

//--- hdl/lsu.sv
// load/store unit, four-phase data port master
`timescale 1ns/1ps

module lsu (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  input  logic            is_store,
  input  rv_pkg::funct3_t mem_size,
  input  rv_pkg::word_t   addr,
  input  rv_pkg::word_t   store_data,
  output rv_pkg::word_t   load_data,
  output logic            mem_done,
  output logic            mem_req,
  input  logic            mem_ack,
  output logic            mem_we,
  output rv_pkg::word_t   mem_addr,
  output rv_pkg::word_t   mem_wdata,
  output rv_pkg::strb_t   mem_strb,
  input  rv_pkg::word_t   mem_rdata
);
  import rv_pkg::*;

  typedef enum logic [1:0] {ls_idle, ls_req, ls_drop} lsu_state_t;

  lsu_state_t state;
  funct3_t    size_q;
  logic [1:0] offset_q;
  word_t      rdata_q, rdata_sh;
  strb_t      strb_n;

  always_comb begin
    case (mem_size)
      f3_byte: strb_n = 4'b0001 << addr[1:0];
      f3_half: strb_n = 4'b0011 << addr[1:0];
      default: strb_n = 4'b1111;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= ls_idle;
      mem_req  <= 1'b0;
      mem_we   <= 1'b0;
      mem_strb <= '0;
      mem_done <= 1'b0;
    end else begin
      mem_done <= 1'b0;
      case (state)
        ls_idle: if (start) begin
          mem_req  <= 1'b1;
          mem_we   <= is_store;
          mem_strb <= is_store ? strb_n : 4'b0000;  // no lanes on reads
          state    <= ls_req;
        end
        ls_req: if (mem_ack) begin
          mem_req <= 1'b0;
          state   <= ls_drop;
        end
        default: if (!mem_ack) begin  // wait for the ack to fall
          mem_done <= 1'b1;
          state    <= ls_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ls_idle && start) begin
      mem_addr  <= {addr[31:2], 2'b00};
      mem_wdata <= store_data << {addr[1:0], 3'b000};
      size_q    <= mem_size;
      offset_q  <= addr[1:0];
    end
    if (state == ls_req && mem_ack) rdata_q <= mem_rdata;
  end

  assign rdata_sh = rdata_q >> {offset_q, 3'b000};

  always_comb begin
    case (size_q)
      f3_byte:   load_data = {{24{rdata_sh[7]}}, rdata_sh[7:0]};
      f3_half:   load_data = {{16{rdata_sh[15]}}, rdata_sh[15:0]};
      f3_byte_u: load_data = {24'b0, rdata_sh[7:0]};
      f3_half_u: load_data = {16'b0, rdata_sh[15:0]};
      default:   load_data = rdata_q;  // lw
    endcase
  end

endmodule

//--- hdl/core_ctrl.sv
// core control FSM and pc
`timescale 1ns/1ps

module core_ctrl (
  input  logic          clk,
  input  logic          rst,
  input  logic          is_load,
  input  logic          is_store,
  input  logic          is_branch,
  input  logic          is_jump,
  input  logic          is_jalr,
  input  logic          is_ecall,
  input  logic          wb_en,
  input  logic          wb_link,
  input  logic          take,
  input  rv_pkg::word_t imm,
  input  rv_pkg::word_t alu_y,
  input  rv_pkg::word_t load_data,
  input  logic          mem_done,
  output rv_pkg::word_t pc,
  output logic          rf_we,
  output rv_pkg::word_t rd_data,
  output logic          mem_start,
  output logic          halt
);
  import rv_pkg::*;

  cpu_state_t state;
  word_t      pc_plus4, next_pc;
  logic       mem_op, retire;

  assign mem_op   = is_load || is_store;
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    if (is_jalr) begin
      next_pc = {alu_y[31:1], 1'b0};
    end else if (is_jump || (is_branch && take)) begin
      next_pc = pc + imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  // instruction completes this cycle
  assign retire = (state == st_exec && !mem_op && !is_ecall) || (state == st_mem && mem_done);

  assign mem_start = (state == st_exec) && mem_op;  // one cycle per access
  assign rf_we     = wb_en && retire;
  assign rd_data   = is_load ? load_data : (wb_link ? pc_plus4 : alu_y);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= st_fetch;
      pc    <= '0;
      halt  <= 1'b0;
    end else begin
      if (retire) pc <= next_pc;
      case (state)
        st_fetch: state <= st_exec;  // rom output valid next cycle
        st_exec: begin
          if (is_ecall) begin
            state <= st_halted;
            halt  <= 1'b1;
          end else if (mem_op) begin
            state <= st_mem;
          end else begin
            state <= st_fetch;
          end
        end
        st_mem: if (mem_done) state <= st_fetch;
        default: state <= st_halted;  // stays until reset
      endcase
    end
  end

endmodule

//--- hdl/cpu_top.sv
// rv32i multicycle core
`timescale 1ns/1ps

module cpu_top (
  input  logic          clk,
  input  logic          rst,
  output logic          halt,
  output logic          mem_req,
  input  logic          mem_ack,
  output logic          mem_we,
  output rv_pkg::word_t mem_addr,
  output rv_pkg::word_t mem_wdata,
  output rv_pkg::strb_t mem_strb,
  input  rv_pkg::word_t mem_rdata
);
  import rv_pkg::*;

  word_t     pc, inst, rs1_data, rs2_data, alu_a, alu_b, alu_y, imm;
  word_t     rd_data, load_data;
  reg_addr_t rs1, rs2, rd;
  alu_op_t   alu_op;
  funct3_t   funct3;
  logic      wb_link, wb_en, is_load, is_store, is_branch, is_jump, is_jalr, is_ecall;
  logic      take, rf_we, mem_start, mem_done;

  core_ctrl u_ctrl (
    .clk(clk), .rst(rst),
    .is_load(is_load), .is_store(is_store), .is_branch(is_branch),
    .is_jump(is_jump), .is_jalr(is_jalr), .is_ecall(is_ecall),
    .wb_en(wb_en), .wb_link(wb_link), .take(take), .imm(imm),
    .alu_y(alu_y), .load_data(load_data), .mem_done(mem_done),
    .pc(pc), .rf_we(rf_we), .rd_data(rd_data), .mem_start(mem_start), .halt(halt)
  );

  inst_rom u_rom (.clk(clk), .pc(pc), .inst(inst));

  decoder u_dec (
    .inst(inst), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rs1(rs1), .rs2(rs2), .rd(rd),
    .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .imm(imm),
    .wb_link(wb_link), .wb_en(wb_en), .is_load(is_load), .is_store(is_store),
    .is_branch(is_branch), .is_jump(is_jump), .is_jalr(is_jalr), .is_ecall(is_ecall),
    .mem_size(funct3)
  );

  reg_file u_rf (
    .clk(clk), .rst(rst), .we(rf_we), .rd(rd), .rd_data(rd_data),
    .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  alu u_alu (
    .op(alu_op), .a(alu_a), .b(alu_b), .funct3(funct3), .y(alu_y),
    .cmp_a(rs1_data), .cmp_b(rs2_data), .take(take)
  );

  // address comes from the alu sum
  lsu u_lsu (
    .clk(clk), .rst(rst), .start(mem_start), .is_store(is_store),
    .mem_size(funct3), .addr(alu_y), .store_data(rs2_data),
    .load_data(load_data), .mem_done(mem_done),
    .mem_req(mem_req), .mem_ack(mem_ack), .mem_we(mem_we), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_strb(mem_strb), .mem_rdata(mem_rdata)
  );

endmodule

//--- sim/clk_gen.sv
// testbench clock and reset
`timescale 1ns/1ps

module clk_gen #(
  parameter int period     = 4,
  parameter int rst_cycles = 8
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (rst_cycles) @(posedge clk);
    @(negedge clk);  // release away from the active edge
    rst = 1'b0;
  end

endmodule

//--- sim/tb_cpu.sv
// rv32i core testbench
`timescale 1ns/1ps

module tb_cpu;
  import rv_pkg::*;

  logic  clk, rst, halt, mem_req, mem_ack, mem_we;
  word_t mem_addr, mem_wdata, mem_rdata;
  strb_t mem_strb;

  word_t       prog [rom_words];
  word_t       mem [64];        // responder storage
  word_t       model_mem [64];
  word_t       exp_addr[$];
  word_t       exp_wdata[$];
  strb_t       exp_strb[$];
  bit          exp_we[$];
  int          errors = 0;
  int          checked = 0;
  int          prog_len = 0;
  bit          model_ready = 1'b0;
  bit          req_q = 1'b0;
  bit          ack_q = 1'b0;
  int unsigned lcg_state = 35;

  clk_gen clk_gen0 (.clk(clk), .rst(rst));

  cpu_top dut0 (
    .clk(clk), .rst(rst), .halt(halt),
    .mem_req(mem_req), .mem_ack(mem_ack), .mem_we(mem_we), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_strb(mem_strb), .mem_rdata(mem_rdata)
  );

  function automatic word_t fill_word(input int idx);
    word_t a;
    a = idx << 2;
    return (a * 32'h9E37_79B1) ^ 32'h8F0F_7170;  // mixed sign bytes
  endfunction

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) & 32'h7fff;
  endfunction

  function automatic word_t lane_mask(input strb_t s);
    return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
  endfunction

  function automatic word_t alu_ref(input funct3_t f3, input bit alt, input word_t a,
                                    input word_t b);
    case (f3)
      3'b000: begin
        if (alt) return a - b;
        return a + b;
      end
      3'b001: return a << b[4:0];
      3'b010: return {31'b0, $signed(a) < $signed(b)};
      3'b011: return {31'b0, a < b};
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) return $signed(a) >>> b[4:0];  // sign fill
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic bit branch_taken(input funct3_t f3, input word_t a, input word_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic void push_expect(input word_t addr, input bit we, input strb_t strb,
                                      input word_t wdata);
    exp_addr.push_back(addr);
    exp_we.push_back(we);
    exp_strb.push_back(strb);
    exp_wdata.push_back(wdata);
  endfunction

  // instruction-set model, builds the expected data-port sequence
  function automatic void run_model();
    word_t regs [32];
    word_t pc, nxt, ins, a, b, res, imm_i, imm_s, imm_b, imm_j, addr, lane, sdata;
    strb_t strb;
    bit    wr, done;
    int    steps;
    int    nbytes;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < 64; i++) model_mem[i] = fill_word(i);
    pc = '0;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 2000) begin
      ins   = prog[(pc >> 2) % rom_words];
      a     = regs[ins[19:15]];
      b     = regs[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      nxt   = pc + 4;
      wr    = 1'b1;
      res   = '0;
      case (ins[6:0])
        op_lui:   res = {ins[31:12], 12'h000};
        op_auipc: res = pc + {ins[31:12], 12'h000};
        op_jal: begin
          res = pc + 4;
          nxt = pc + imm_j;
        end
        op_jalr: begin
          res = pc + 4;
          nxt = (a + imm_i) & ~32'd1;
        end
        op_branch: begin
          wr = 1'b0;
          if (branch_taken(ins[14:12], a, b)) nxt = pc + imm_b;
        end
        op_load: begin
          addr = a + imm_i;
          push_expect(addr & ~32'd3, 1'b0, 4'b0000, '0);
          lane = model_mem[addr[7:2]] >> (8 * addr[1:0]);
          case (ins[14:12])
            f3_byte:   res = {{24{lane[7]}}, lane[7:0]};
            f3_half:   res = {{16{lane[15]}}, lane[15:0]};
            f3_byte_u: res = {24'b0, lane[7:0]};
            f3_half_u: res = {16'b0, lane[15:0]};
            default:   res = lane;
          endcase
        end
        op_store: begin
          wr     = 1'b0;
          addr   = a + imm_s;
          sdata  = b << (8 * addr[1:0]);
          nbytes = (ins[14:12] == f3_byte) ? 1 : ((ins[14:12] == f3_half) ? 2 : 4);
          // lanes touched by the access
          for (int l = 0; l < 4; l++) begin
            strb[l] = (l >= addr[1:0]) && (l < addr[1:0] + nbytes);
          end
          push_expect(addr & ~32'd3, 1'b1, strb, sdata);
          for (int l = 0; l < 4; l++) begin
            if (strb[l]) model_mem[addr[7:2]][8*l +: 8] = sdata[8*l +: 8];
          end
        end
        op_reg_imm: res = alu_ref(ins[14:12], ins[14:12] == 3'b101 && ins[30], a, imm_i);
        op_reg_reg: res = alu_ref(ins[14:12], ins[30], a, b);
        default: begin  // ecall ends the program
          wr   = 1'b0;
          done = 1'b1;
        end
      endcase
      if (wr && ins[11:7] != 5'd0) regs[ins[11:7]] = res;
      if (!done) pc = nxt;
      steps++;
    end
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_strb(input string name, input strb_t got, input strb_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic finish_run(input bit timed_out);
    $display("errors: %0d, requests checked: %0d", errors, checked);
    if (errors == 0 && !timed_out) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  // data memory, random ack delay per request
  initial begin : responder
    int unsigned delay;
    int          widx;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    for (int i = 0; i < 64; i++) mem[i] = fill_word(i);
    forever begin
      @(negedge clk);
      if (mem_req && rst === 1'b0) begin
        delay = lcg_next() % 6;
        repeat (delay) @(negedge clk);
        widx = mem_addr[7:2];
        if (mem_we) begin
          for (int l = 0; l < 4; l++) begin
            if (mem_strb[l]) mem[widx][8*l +: 8] = mem_wdata[8*l +: 8];
          end
        end else begin
          mem_rdata = mem[widx];
        end
        mem_ack = 1'b1;
        do @(negedge clk); while (mem_req);
        mem_ack = 1'b0;
      end
    end
  end

  // values read here are the ones held since the last falling edge
  always @(posedge clk) begin : compare
    word_t e_addr, e_wdata;
    strb_t e_strb;
    bit    e_we;
    if (rst === 1'b0 && mem_req && !req_q) begin
      if (ack_q) begin
        errors++;
        $display("mem_req rose at %0t ns while mem_ack was still high", $time);
      end
      if (exp_addr.size() == 0) begin
        errors++;
        $display("unexpected data request at %0t ns to %h", $time, mem_addr);
      end else begin
        e_addr  = exp_addr.pop_front();
        e_we    = exp_we.pop_front();
        e_strb  = exp_strb.pop_front();
        e_wdata = exp_wdata.pop_front();
        check_word("mem_addr", mem_addr, e_addr);
        check_bit("mem_we", mem_we, e_we);
        check_strb("mem_strb", mem_strb, e_strb);
        if (e_we) begin
          check_word("mem_wdata", mem_wdata & lane_mask(e_strb), e_wdata & lane_mask(e_strb));
        end
        checked++;
      end
    end
    req_q = mem_req;
    ack_q = mem_ack;
  end

  initial begin : main
    $readmemh("sim/prog.hex", prog);
    for (int i = 0; i < rom_words; i++) begin
      if (!$isunknown(prog[i])) prog_len++;
    end
    run_model();
    model_ready = 1'b1;
    wait (rst === 1'b0);
    @(negedge clk);
    check_bit("halt", halt, 1'b0);
    wait (halt === 1'b1);
    repeat (10) begin  // halt holds, port stays quiet
      @(negedge clk);
      check_bit("halt", halt, 1'b1);
      check_bit("mem_req", mem_req, 1'b0);
    end
    if (exp_addr.size() != 0) begin
      errors++;
      $display("%0d expected data requests never happened", exp_addr.size());
    end
    finish_run(1'b0);
  end

  initial begin : watchdog
    wait (model_ready);
    #(prog_len * 20 * 4);
    $display("timeout, the core did not halt within %0d ns", prog_len * 20 * 4);
    finish_run(1'b1);
  end

endmodule

//--- sim/prog.hex
// rv32i test program, one instruction word per line
// line n holds the word at pc 4*n, data results go to 0x80 and up
08000093 // addi x1, x0, 0x80
F9C00113 // addi x2, x0, -100
00700193 // addi x3, x0, 7
40315233 // sra  x4, x2, x3
403102B3 // sub  x5, x2, x3
00313333 // sltu x6, x2, x3
FFF12393 // slti x7, x2, -1
0040A023 // sw   x4, 0(x1)
0050A223 // sw   x5, 4(x1)
0060A423 // sw   x6, 8(x1)
0070A623 // sw   x7, 12(x1)
002088A3 // sb   x2, 17(x1)
002089A3 // sb   x2, 19(x1)
00209B23 // sh   x2, 22(x1)
04300503 // lb   x10, 0x43(x0)
04104583 // lbu  x11, 0x41(x0)
04601603 // lh   x12, 0x46(x0)
04405683 // lhu  x13, 0x44(x0)
09402703 // lw   x14, 0x94(x0)
00A0AC23 // sw   x10, 24(x1)
00B0AE23 // sw   x11, 28(x1)
02C0A023 // sw   x12, 32(x1)
02D0A223 // sw   x13, 36(x1)
02E0A423 // sw   x14, 40(x1)
00500013 // addi x0, x0, 5
0200A623 // sw   x0, 44(x1)
123457B7 // lui  x15, 0x12345
00310463 // beq  x2, x3, +8   not taken
00311463 // bne  x2, x3, +8   taken
00178793 // addi x15, x15, 1
0021C463 // blt  x3, x2, +8   not taken
0021D463 // bge  x3, x2, +8   taken
00278793 // addi x15, x15, 2
00316463 // bltu x2, x3, +8   not taken
00317463 // bgeu x2, x3, +8   taken
00478793 // addi x15, x15, 4
0080086F // jal  x16, +8
00878793 // addi x15, x15, 8
00000897 // auipc x17, 0
00C88967 // jalr x18, 12(x17)
01078793 // addi x15, x15, 16
02F0A823 // sw   x15, 48(x1)
0300AA23 // sw   x16, 52(x1)
0320AC23 // sw   x18, 56(x1)
00000073 // ecall

//--- build.f
hdl/rv_pkg.sv
hdl/inst_rom.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/lsu.sv
hdl/core_ctrl.sv
hdl/cpu_top.sv
sim/clk_gen.sv
sim/tb_cpu.sv
